//--- logic/tdd_timing_pkg.sv
package tdd_timing_pkg;

  // ******************************
  // counter widths
  // ******************************

  localparam int COUNT_W = 24;
  localparam int BURST_W = 8;

  // counter value, also used for every counter-valued setting
  typedef logic [COUNT_W-1:0] count_t;

  // frames per burst, zero runs without end
  typedef logic [BURST_W-1:0] burst_t;

  // ******************************
  // controlled channels
  // ******************************

  localparam int NUM_CHAN = 4;

  typedef logic [NUM_CHAN-1:0] chan_vec_t;

  localparam int CH_RX_RF = 0;
  localparam int CH_TX_RF = 1;
  localparam int CH_RX_DP = 2;
  localparam int CH_TX_DP = 3;

  // timer state
  typedef enum logic {
    TDD_OFF = 1'b0,
    TDD_ON  = 1'b1
  } tdd_state_t;

endpackage

//--- logic/tdd_regmap_pkg.sv
package tdd_regmap_pkg;

  // word address and data of the wishbone slave
  typedef logic [3:0]  wb_adr_t;
  typedef logic [31:0] wb_dat_t;

  // ******************************
  // register addresses
  // ******************************

  localparam wb_adr_t REG_CTRL      = 4'd0;
  localparam wb_adr_t REG_BURST     = 4'd1;
  localparam wb_adr_t REG_INIT      = 4'd2;
  localparam wb_adr_t REG_FRAME_LEN = 4'd3;
  localparam wb_adr_t REG_WIN_BASE  = 4'd4;
  // read-only, live frame counter
  localparam wb_adr_t REG_STATUS    = 4'd12;

  // bits of REG_CTRL
  localparam int CTRL_ENABLE  = 0;
  localparam int CTRL_TX_ONLY = 1;
  localparam int CTRL_RX_ONLY = 2;

  // on value of a channel, off value sits right above it
  function automatic wb_adr_t win_on_adr(int chan);
    return wb_adr_t'(int'(REG_WIN_BASE) + 2 * chan);
  endfunction

  function automatic wb_adr_t win_off_adr(int chan);
    return wb_adr_t'(int'(REG_WIN_BASE) + 2 * chan + 1);
  endfunction

endpackage

//--- logic/tdd_cfg_if.sv
`timescale 1ns/1ps

interface tdd_cfg_if;

  import tdd_timing_pkg::*;

  // control bits
  logic   enable;
  logic   tx_only;
  logic   rx_only;

  // frame and burst setup
  burst_t burst_count;
  count_t counter_init;
  count_t frame_length;

  // programmed window per channel
  count_t on_value  [NUM_CHAN];
  count_t off_value [NUM_CHAN];

  // register file is the only driver
  modport regs (
    output enable,
    output tx_only,
    output rx_only,
    output burst_count,
    output counter_init,
    output frame_length,
    output on_value,
    output off_value
  );

  modport timer (
    input enable,
    input burst_count,
    input counter_init,
    input frame_length
  );

  modport window (
    input frame_length,
    input on_value,
    input off_value
  );

  modport enable_gen (
    input tx_only,
    input rx_only
  );

endinterface

//--- logic/tdd_regs.sv
`timescale 1ns/1ps

module tdd_regs (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    i_wb_cyc,
  input  logic                    i_wb_stb,
  input  logic                    i_wb_we,
  input  tdd_regmap_pkg::wb_adr_t i_wb_adr,
  input  tdd_regmap_pkg::wb_dat_t i_wb_dat,
  output tdd_regmap_pkg::wb_dat_t o_wb_dat,
  output logic                    o_wb_ack,
  input  tdd_timing_pkg::count_t  i_frame_count,
  tdd_cfg_if.regs                 cfg
);

  import tdd_timing_pkg::*;
  import tdd_regmap_pkg::*;

  logic    wb_req;
  logic    wb_wr;
  wb_dat_t rd_data;

  // new request, ack not yet given
  assign wb_req = i_wb_cyc && i_wb_stb && !o_wb_ack;
  assign wb_wr  = wb_req && i_wb_we;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_wb_ack <= 1'b0;
    end else begin
      o_wb_ack <= wb_req;
    end
  end

  // ******************************
  // setting registers
  // ******************************

  always_ff @(posedge clk) begin
    if (rst) begin
      cfg.enable       <= 1'b0;
      cfg.tx_only      <= 1'b0;
      cfg.rx_only      <= 1'b0;
      cfg.burst_count  <= '0;
      cfg.counter_init <= '0;
      cfg.frame_length <= '0;
      for (int c = 0; c < NUM_CHAN; c++) begin
        cfg.on_value[c]  <= '0;
        cfg.off_value[c] <= '0;
      end
    end else if (wb_wr) begin
      case (i_wb_adr)
        REG_CTRL: begin
          cfg.enable  <= i_wb_dat[CTRL_ENABLE];
          cfg.tx_only <= i_wb_dat[CTRL_TX_ONLY];
          cfg.rx_only <= i_wb_dat[CTRL_RX_ONLY];
        end
        REG_BURST:     cfg.burst_count  <= i_wb_dat[BURST_W-1:0];
        REG_INIT:      cfg.counter_init <= i_wb_dat[COUNT_W-1:0];
        REG_FRAME_LEN: cfg.frame_length <= i_wb_dat[COUNT_W-1:0];
        // status and unmapped addresses drop the write
        default: ;
      endcase
      for (int c = 0; c < NUM_CHAN; c++) begin
        if (i_wb_adr == win_on_adr(c)) begin
          cfg.on_value[c] <= i_wb_dat[COUNT_W-1:0];
        end
        if (i_wb_adr == win_off_adr(c)) begin
          cfg.off_value[c] <= i_wb_dat[COUNT_W-1:0];
        end
      end
    end
  end

  // ******************************
  // readback
  // ******************************

  always_comb begin
    rd_data = '0;
    case (i_wb_adr)
      REG_CTRL: begin
        rd_data[CTRL_ENABLE]  = cfg.enable;
        rd_data[CTRL_TX_ONLY] = cfg.tx_only;
        rd_data[CTRL_RX_ONLY] = cfg.rx_only;
      end
      REG_BURST:     rd_data = wb_dat_t'(cfg.burst_count);
      REG_INIT:      rd_data = wb_dat_t'(cfg.counter_init);
      REG_FRAME_LEN: rd_data = wb_dat_t'(cfg.frame_length);
      REG_STATUS:    rd_data = wb_dat_t'(i_frame_count);
      default: ;
    endcase
    for (int c = 0; c < NUM_CHAN; c++) begin
      if (i_wb_adr == win_on_adr(c)) begin
        rd_data = wb_dat_t'(cfg.on_value[c]);
      end
      if (i_wb_adr == win_off_adr(c)) begin
        rd_data = wb_dat_t'(cfg.off_value[c]);
      end
    end
  end

  // captured with the ack edge, held while ack is high
  always_ff @(posedge clk) begin
    if (wb_req) begin
      o_wb_dat <= rd_data;
    end
  end

endmodule

//--- logic/tdd_frame_timer.sv
`timescale 1ns/1ps

module tdd_frame_timer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_sync,
  tdd_cfg_if.timer               cfg,
  output logic                   o_running,
  output tdd_timing_pkg::count_t o_frame_count
);

  import tdd_timing_pkg::*;

  logic       sync_d1;
  logic       sync_d2;
  logic       sync_d3;
  logic       sync_edge;
  tdd_state_t state;
  tdd_state_t state_next;
  logic       end_of_frame;
  logic       end_of_burst;
  burst_t     burst_cnt;
  logic       last_burst;

  // sync input, rising edge seen between flop two and three
  always_ff @(posedge clk) begin
    if (rst) begin
      sync_d1 <= 1'b0;
      sync_d2 <= 1'b0;
      sync_d3 <= 1'b0;
    end else begin
      sync_d1 <= i_sync;
      sync_d2 <= sync_d1;
      sync_d3 <= sync_d2;
    end
  end

  assign sync_edge    = sync_d2 && !sync_d3;
  assign end_of_frame = (o_frame_count == cfg.frame_length);
  assign end_of_burst = last_burst && end_of_frame;

  // ******************************
  // on/off state machine
  // ******************************

  always_comb begin
    state_next = state;
    case (state)
      TDD_OFF: begin
        if (cfg.enable && sync_edge) begin
          state_next = TDD_ON;
        end
      end
      TDD_ON: begin
        if (!cfg.enable || end_of_burst) begin
          state_next = TDD_OFF;
        end
      end
      default: state_next = TDD_OFF;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= TDD_OFF;
    end else begin
      state <= state_next;
    end
  end

  assign o_running = (state == TDD_ON);

  // frame counter, restarts at zero on a sync edge while on
  always_ff @(posedge clk) begin
    if (rst) begin
      o_frame_count <= '0;
    end else if (state == TDD_ON) begin
      if (sync_edge) begin
        o_frame_count <= '0;
      end else if (o_frame_count < cfg.frame_length) begin
        o_frame_count <= o_frame_count + 1'b1;
      end else begin
        o_frame_count <= '0;
      end
    end else begin
      o_frame_count <= cfg.counter_init;
    end
  end

  // burst counter counts frames down to one, zero never expires
  always_ff @(posedge clk) begin
    if (rst) begin
      burst_cnt  <= '0;
      last_burst <= 1'b0;
    end else begin
      if (state == TDD_ON) begin
        if (end_of_frame && (burst_cnt != '0)) begin
          burst_cnt <= burst_cnt - 1'b1;
        end
      end else begin
        burst_cnt <= cfg.burst_count;
      end
      last_burst <= (burst_cnt == burst_t'(1));
    end
  end

endmodule

//--- logic/tdd_window_match.sv
`timescale 1ns/1ps

module tdd_window_match #(
  parameter int CTRL_DELAY = 2
) (
  input  logic                      clk,
  input  logic                      rst,
  input  tdd_timing_pkg::count_t    i_frame_count,
  tdd_cfg_if.window                 cfg,
  output tdd_timing_pkg::chan_vec_t o_on_hit,
  output tdd_timing_pkg::chan_vec_t o_off_hit
);

  import tdd_timing_pkg::*;

  localparam count_t DELAY = count_t'(CTRL_DELAY);

  count_t on_target  [NUM_CHAN];
  count_t off_target [NUM_CHAN];

  // move a window edge ahead by the control delay, wrapping into the previous frame
  function automatic count_t comp_target(count_t value, count_t frame_len);
    count_t target;
    if (value >= DELAY) begin
      target = value - DELAY;
    end else begin
      target = value + frame_len + count_t'(1) - DELAY;
    end
    return target;
  endfunction

  always_ff @(posedge clk) begin
    for (int c = 0; c < NUM_CHAN; c++) begin
      on_target[c]  <= comp_target(cfg.on_value[c], cfg.frame_length);
      off_target[c] <= comp_target(cfg.off_value[c], cfg.frame_length);
    end
  end

  // one-cycle hit pulses
  always_ff @(posedge clk) begin
    if (rst) begin
      o_on_hit  <= '0;
      o_off_hit <= '0;
    end else begin
      for (int c = 0; c < NUM_CHAN; c++) begin
        o_on_hit[c]  <= (i_frame_count == on_target[c]);
        o_off_hit[c] <= (i_frame_count == off_target[c]);
      end
    end
  end

endmodule

//--- logic/tdd_enable_gen.sv
`timescale 1ns/1ps

module tdd_enable_gen (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_running,
  input  tdd_timing_pkg::chan_vec_t i_on_hit,
  input  tdd_timing_pkg::chan_vec_t i_off_hit,
  tdd_cfg_if.enable_gen             cfg,
  output tdd_timing_pkg::chan_vec_t o_chan_en
);

  import tdd_timing_pkg::*;

  // channels that follow tx_only, the rest follow rx_only
  localparam chan_vec_t TX_MASK = chan_vec_t'((1 << CH_TX_RF) | (1 << CH_TX_DP));

  logic one_dir_only;

  // both or neither set means windows alone decide
  assign one_dir_only = cfg.tx_only ^ cfg.rx_only;

  // ******************************
  // enable flops
  // ******************************

  always_ff @(posedge clk) begin
    if (rst) begin
      o_chan_en <= '0;
    end else begin
      for (int c = 0; c < NUM_CHAN; c++) begin
        if (!i_running || i_off_hit[c]) begin
          // off wins over on when both hit together
          o_chan_en[c] <= 1'b0;
        end else if (i_on_hit[c]) begin
          o_chan_en[c] <= 1'b1;
        end else if (one_dir_only) begin
          if (TX_MASK[c]) begin
            o_chan_en[c] <= cfg.tx_only;
          end else begin
            o_chan_en[c] <= cfg.rx_only;
          end
        end
      end
    end
  end

endmodule

//--- logic/tdd_control.sv
`timescale 1ns/1ps

module tdd_control #(
  parameter int CTRL_DELAY = 2
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    i_wb_cyc,
  input  logic                    i_wb_stb,
  input  logic                    i_wb_we,
  input  tdd_regmap_pkg::wb_adr_t i_wb_adr,
  input  tdd_regmap_pkg::wb_dat_t i_wb_dat,
  output tdd_regmap_pkg::wb_dat_t o_wb_dat,
  output logic                    o_wb_ack,
  input  logic                    i_sync,
  output logic                    o_rx_rf_en,
  output logic                    o_tx_rf_en,
  output logic                    o_rx_dp_en,
  output logic                    o_tx_dp_en,
  output tdd_timing_pkg::count_t  o_counter_status
);

  import tdd_timing_pkg::*;

  logic      running;
  count_t    frame_count;
  chan_vec_t on_hit;
  chan_vec_t off_hit;
  chan_vec_t chan_en;

  tdd_cfg_if cfg ();

  // ******************************
  // register file and pipeline
  // ******************************

  tdd_regs regs_i (
    .clk           (clk),
    .rst           (rst),
    .i_wb_cyc      (i_wb_cyc),
    .i_wb_stb      (i_wb_stb),
    .i_wb_we       (i_wb_we),
    .i_wb_adr      (i_wb_adr),
    .i_wb_dat      (i_wb_dat),
    .o_wb_dat      (o_wb_dat),
    .o_wb_ack      (o_wb_ack),
    .i_frame_count (frame_count),
    .cfg           (cfg)
  );

  tdd_frame_timer timer_i (
    .clk           (clk),
    .rst           (rst),
    .i_sync        (i_sync),
    .cfg           (cfg),
    .o_running     (running),
    .o_frame_count (frame_count)
  );

  tdd_window_match #(
    .CTRL_DELAY (CTRL_DELAY)
  ) window_i (
    .clk           (clk),
    .rst           (rst),
    .i_frame_count (frame_count),
    .cfg           (cfg),
    .o_on_hit      (on_hit),
    .o_off_hit     (off_hit)
  );

  tdd_enable_gen enable_i (
    .clk       (clk),
    .rst       (rst),
    .i_running (running),
    .i_on_hit  (on_hit),
    .i_off_hit (off_hit),
    .cfg       (cfg),
    .o_chan_en (chan_en)
  );

  assign o_rx_rf_en       = chan_en[CH_RX_RF];
  assign o_tx_rf_en       = chan_en[CH_TX_RF];
  assign o_rx_dp_en       = chan_en[CH_RX_DP];
  assign o_tx_dp_en       = chan_en[CH_TX_DP];
  assign o_counter_status = frame_count;

endmodule

//--- tb/tdd_control_tb.sv
`timescale 1ns/1ps

module tdd_control_tb;

  import tdd_timing_pkg::*;
  import tdd_regmap_pkg::*;

  localparam int CTRL_DELAY = 2;
  localparam int BUS_WAIT   = 8;

  // rough cycle budget per test, run stops at twice the sum
  localparam int LEN_RESET    = 20;
  localparam int LEN_REGS     = 100;
  localparam int LEN_FRAME    = 160;
  localparam int LEN_WINDOW   = 200;
  localparam int LEN_BURST    = 160;
  localparam int LEN_OVERRIDE = 80;
  localparam int CYCLE_LIMIT  = 2 * (LEN_RESET + LEN_REGS + LEN_FRAME + LEN_WINDOW
                                     + LEN_BURST + LEN_OVERRIDE);

  logic      clk;
  logic      rst;
  logic      i_wb_cyc;
  logic      i_wb_stb;
  logic      i_wb_we;
  wb_adr_t   i_wb_adr;
  wb_dat_t   i_wb_dat;
  wb_dat_t   o_wb_dat;
  logic      o_wb_ack;
  logic      i_sync;
  logic      o_rx_rf_en;
  logic      o_tx_rf_en;
  logic      o_rx_dp_en;
  logic      o_tx_dp_en;
  count_t    o_counter_status;
  chan_vec_t dut_en;

  // bookkeeping
  string     cur_test;
  int        test_errors;
  int        total_errors;
  int        tests_run;
  int        tests_failed;
  int        cycle_cnt;
  logic      check_on;
  logic [15:0] lfsr_state;

  // reference model state
  logic      m_ack;
  logic      m_en;
  logic      m_tx;
  logic      m_rx;
  burst_t    m_burst;
  count_t    m_init;
  count_t    m_fl;
  count_t    m_on [NUM_CHAN];
  count_t    m_off [NUM_CHAN];
  logic      m_s1;
  logic      m_s2;
  logic      m_s3;
  logic      m_run;
  count_t    m_cnt;
  burst_t    m_bc;
  logic      m_last;
  count_t    m_ont [NUM_CHAN];
  count_t    m_offt [NUM_CHAN];
  chan_vec_t m_onh;
  chan_vec_t m_offh;
  chan_vec_t m_chen;

  tdd_control #(
    .CTRL_DELAY (CTRL_DELAY)
  ) dut_i (
    .clk              (clk),
    .rst              (rst),
    .i_wb_cyc         (i_wb_cyc),
    .i_wb_stb         (i_wb_stb),
    .i_wb_we          (i_wb_we),
    .i_wb_adr         (i_wb_adr),
    .i_wb_dat         (i_wb_dat),
    .o_wb_dat         (o_wb_dat),
    .o_wb_ack         (o_wb_ack),
    .i_sync           (i_sync),
    .o_rx_rf_en       (o_rx_rf_en),
    .o_tx_rf_en       (o_tx_rf_en),
    .o_rx_dp_en       (o_rx_dp_en),
    .o_tx_dp_en       (o_tx_dp_en),
    .o_counter_status (o_counter_status)
  );

  assign dut_en[CH_RX_RF] = o_rx_rf_en;
  assign dut_en[CH_TX_RF] = o_tx_rf_en;
  assign dut_en[CH_RX_DP] = o_rx_dp_en;
  assign dut_en[CH_TX_DP] = o_tx_dp_en;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ******************************
  // random values
  // ******************************

  function automatic logic [15:0] lfsr_next(logic [15:0] state);
    return (state >> 1) ^ (state[0] ? 16'hB400 : 16'h0000);
  endfunction

  function automatic wb_dat_t rand_bits(int nbits);
    wb_dat_t value;
    value = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  function automatic wb_dat_t rand_below(int limit);
    return rand_bits(8) % wb_dat_t'(limit);
  endfunction

  // ******************************
  // reference model
  // ******************************

  // window edge moved ahead by the control delay, wraps into the previous frame
  function automatic count_t compensate(count_t value, count_t frame_len);
    if (value >= count_t'(CTRL_DELAY)) begin
      return value - count_t'(CTRL_DELAY);
    end else begin
      return value + frame_len + count_t'(1) - count_t'(CTRL_DELAY);
    end
  endfunction

  // one clock edge, later pipeline stages first so each sees old values
  function automatic void model_step();
    logic sync_edge;
    logic eof;
    logic req;
    logic one_dir;
    logic run_n;
    int   chan;
    sync_edge = m_s2 && !m_s3;
    eof       = (m_cnt == m_fl);
    req       = i_wb_cyc && i_wb_stb && !m_ack;
    one_dir   = m_tx ^ m_rx;
    for (int c = 0; c < NUM_CHAN; c++) begin
      if (rst || !m_run || m_offh[c]) begin
        m_chen[c] = 1'b0;
      end else if (m_onh[c]) begin
        m_chen[c] = 1'b1;
      end else if (one_dir) begin
        m_chen[c] = (c == CH_TX_RF || c == CH_TX_DP) ? m_tx : m_rx;
      end
      m_onh[c]  = !rst && (m_cnt == m_ont[c]);
      m_offh[c] = !rst && (m_cnt == m_offt[c]);
      m_ont[c]  = compensate(m_on[c], m_fl);
      m_offt[c] = compensate(m_off[c], m_fl);
    end
    if (rst) begin
      m_run  = 1'b0;
      m_cnt  = '0;
      m_bc   = '0;
      m_last = 1'b0;
    end else begin
      run_n = m_run ? (m_en && !(m_last && eof)) : (m_en && sync_edge);
      if (!m_run) begin
        m_cnt = m_init;
      end else if (sync_edge || eof) begin
        m_cnt = '0;
      end else begin
        m_cnt = m_cnt + count_t'(1);
      end
      m_last = (m_bc == burst_t'(1));
      if (!m_run) begin
        m_bc = m_burst;
      end else if (eof && m_bc != '0) begin
        m_bc = m_bc - burst_t'(1);
      end
      m_run = run_n;
    end
    m_s3 = !rst && m_s2;
    m_s2 = !rst && m_s1;
    m_s1 = !rst && i_sync;
    if (rst) begin
      m_en    = 1'b0;
      m_tx    = 1'b0;
      m_rx    = 1'b0;
      m_burst = '0;
      m_init  = '0;
      m_fl    = '0;
      for (int c = 0; c < NUM_CHAN; c++) begin
        m_on[c]  = '0;
        m_off[c] = '0;
      end
    end else if (req && i_wb_we) begin
      if (i_wb_adr == REG_CTRL) begin
        m_en = i_wb_dat[0];
        m_tx = i_wb_dat[1];
        m_rx = i_wb_dat[2];
      end else if (i_wb_adr == REG_BURST) begin
        m_burst = i_wb_dat[7:0];
      end else if (i_wb_adr == REG_INIT) begin
        m_init = i_wb_dat[23:0];
      end else if (i_wb_adr == REG_FRAME_LEN) begin
        m_fl = i_wb_dat[23:0];
      end else if (i_wb_adr >= REG_WIN_BASE && i_wb_adr < REG_STATUS) begin
        chan = (int'(i_wb_adr) - 4) / 2;
        if (i_wb_adr[0]) begin
          m_off[chan] = i_wb_dat[23:0];
        end else begin
          m_on[chan] = i_wb_dat[23:0];
        end
      end
    end
    m_ack = !rst && req;
  endfunction

  always @(posedge clk) begin
    model_step();
  end

  // ******************************
  // reporting
  // ******************************

  task automatic report_error(input string what, input wb_dat_t exp, input wb_dat_t act);
    test_errors++;
    $display("** Error [%s] %s: expected %0h, actual %0h", cur_test, what, exp, act);
  endtask

  task automatic report_failure(input string msg);
    test_errors++;
    $display("[%s] %s", cur_test, msg);
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("test %s: passed", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", cur_test, test_errors);
    end
  endtask

  // outputs compared away from the rising edge
  always @(negedge clk) begin
    if (check_on) begin
      if (dut_en !== m_chen) begin
        report_error("enables", wb_dat_t'(m_chen), wb_dat_t'(dut_en));
      end
      if (o_counter_status !== m_cnt) begin
        report_error("status", wb_dat_t'(m_cnt), wb_dat_t'(o_counter_status));
      end
      if (o_wb_ack !== m_ack) begin
        report_error("ack", wb_dat_t'(m_ack), wb_dat_t'(o_wb_ack));
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display(">>> FAIL");
      $finish;
    end
  end

  // ******************************
  // stimulus tasks
  // ******************************

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wb_access(input logic we, input wb_adr_t adr, input wb_dat_t wdat,
                           output wb_dat_t rdat);
    int waited;
    waited = 0;
    @(posedge clk);
    #1;
    i_wb_cyc = 1'b1;
    i_wb_stb = 1'b1;
    i_wb_we  = we;
    i_wb_adr = adr;
    i_wb_dat = wdat;
    do begin
      @(posedge clk);
      #1;
      waited++;
    end while (!o_wb_ack && waited < BUS_WAIT);
    if (!o_wb_ack) begin
      report_failure($sformatf("no ack for access to address %0d", adr));
    end
    rdat     = o_wb_dat;
    i_wb_cyc = 1'b0;
    i_wb_stb = 1'b0;
    i_wb_we  = 1'b0;
  endtask

  task automatic wb_write(input wb_adr_t adr, input wb_dat_t wdat);
    wb_dat_t unused;
    wb_access(1'b1, adr, wdat, unused);
  endtask

  task automatic wb_read(input wb_adr_t adr, output wb_dat_t rdat);
    wb_access(1'b0, adr, '0, rdat);
  endtask

  task automatic sync_pulse();
    @(posedge clk);
    #1;
    i_sync = 1'b1;
    @(posedge clk);
    #1;
    i_sync = 1'b0;
  endtask

  task automatic wait_status(input count_t value, input int limit);
    int waited;
    waited = 0;
    while (o_counter_status !== value && waited < limit) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (o_counter_status !== value) begin
      report_failure($sformatf("status did not reach %0d within %0d cycles", value, limit));
    end
  endtask

  // frame length first, so the init value never sits above it
  task automatic setup_frame(input int frame_len, input int init, input int bursts);
    wb_write(REG_FRAME_LEN, wb_dat_t'(frame_len));
    wb_write(REG_INIT, wb_dat_t'(init));
    wb_write(REG_BURST, wb_dat_t'(bursts));
  endtask

  task automatic program_windows(input int frame_len);
    for (int c = 0; c < NUM_CHAN; c++) begin
      wb_write(wb_adr_t'(4 + 2 * c), rand_below(frame_len + 1));
      wb_write(wb_adr_t'(5 + 2 * c), rand_below(frame_len + 1));
    end
  endtask

  function automatic wb_dat_t reg_mask(int adr);
    if (adr == 0) begin
      return 32'h7;
    end else if (adr == 1) begin
      return 32'hFF;
    end else if (adr < 12) begin
      return 32'hFF_FFFF;
    end
    return '0;
  endfunction

  // ******************************
  // test sequence
  // ******************************

  initial begin
    wb_dat_t rdat;
    wb_dat_t wdat;
    wb_dat_t exp_regs [12];
    rst          = 1'b1;
    i_wb_cyc     = 1'b0;
    i_wb_stb     = 1'b0;
    i_wb_we      = 1'b0;
    i_wb_adr     = '0;
    i_wb_dat     = '0;
    i_sync       = 1'b0;
    check_on     = 1'b0;
    cycle_cnt    = 0;
    test_errors  = 0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    lfsr_state   = 16'd10468;
    cur_test     = "reset";
    repeat (4) @(posedge clk);
    #1;
    rst      = 1'b0;
    check_on = 1'b1;

    start_test("reset");
    if (dut_en !== '0) begin
      report_error("enables after reset", '0, wb_dat_t'(dut_en));
    end
    if (o_wb_ack !== 1'b0) begin
      report_error("ack after reset", '0, wb_dat_t'(o_wb_ack));
    end
    if (o_counter_status !== '0) begin
      report_error("status after reset", '0, wb_dat_t'(o_counter_status));
    end
    wb_write(REG_INIT, 32'd5);
    idle(1);
    if (o_counter_status !== count_t'(5)) begin
      report_error("idle status", 32'd5, wb_dat_t'(o_counter_status));
    end
    end_test();

    start_test("registers");
    for (int a = 0; a < 12; a++) begin
      wdat        = rand_bits(32);
      exp_regs[a] = wdat & reg_mask(a);
      wb_write(wb_adr_t'(a), wdat);
    end
    for (int a = 0; a < 12; a++) begin
      wb_read(wb_adr_t'(a), rdat);
      if (rdat !== exp_regs[a]) begin
        report_error($sformatf("register %0d", a), exp_regs[a], rdat);
      end
    end
    // status follows the init value while idle
    wb_write(REG_STATUS, rand_bits(32));
    wb_read(REG_STATUS, rdat);
    if (rdat !== exp_regs[2]) begin
      report_error("status register", exp_regs[2], rdat);
    end
    wb_read(wb_adr_t'(13), rdat);
    if (rdat !== '0) begin
      report_error("unmapped register", '0, rdat);
    end
    wb_write(REG_CTRL, '0);
    end_test();

    start_test("frames");
    setup_frame(19, 7, 0);
    program_windows(19);
    wb_write(REG_CTRL, 32'h1);
    sync_pulse();
    wait_status(count_t'(19), 40);
    idle(1);
    if (o_counter_status !== '0) begin
      report_error("wrap", '0, wb_dat_t'(o_counter_status));
    end
    idle(5);
    sync_pulse();
    wait_status('0, 2);
    idle(40);
    wb_write(REG_CTRL, '0);
    idle(3);
    end_test();

    start_test("windows");
    setup_frame(29, 0, 0);
    program_windows(29);
    // values below the control delay
    wb_write(wb_adr_t'(4 + 2 * CH_RX_RF), 32'd1);
    wb_write(wb_adr_t'(5 + 2 * CH_TX_RF), 32'd0);
    wb_write(REG_CTRL, 32'h1);
    sync_pulse();
    idle(120);
    wb_write(REG_CTRL, '0);
    idle(3);
    end_test();

    start_test("burst");
    setup_frame(9, 3, 3);
    program_windows(9);
    wb_write(REG_CTRL, 32'h1);
    sync_pulse();
    idle(40);
    if (dut_en !== '0) begin
      report_error("enables after three frames", '0, wb_dat_t'(dut_en));
    end
    if (o_counter_status !== count_t'(3)) begin
      report_error("status after three frames", 32'd3, wb_dat_t'(o_counter_status));
    end
    wb_write(REG_BURST, '0);
    sync_pulse();
    idle(31);
    // counter starts at 3 two edges after the pulse, frame of ten cycles
    if (o_counter_status !== count_t'(2)) begin
      report_error("free-running status", 32'd2, wb_dat_t'(o_counter_status));
    end
    wb_write(REG_CTRL, '0);
    idle(3);
    if (dut_en !== '0) begin
      report_error("enables after disable", '0, wb_dat_t'(dut_en));
    end
    if (o_counter_status !== count_t'(3)) begin
      report_error("status after disable", 32'd3, wb_dat_t'(o_counter_status));
    end
    end_test();

    start_test("override");
    setup_frame(15, 0, 0);
    // targets above the frame never hit
    for (int c = 0; c < NUM_CHAN; c++) begin
      wb_write(wb_adr_t'(4 + 2 * c), 32'd25);
      wb_write(wb_adr_t'(5 + 2 * c), 32'd25);
    end
    wb_write(REG_CTRL, 32'h3);
    sync_pulse();
    idle(15);
    // both tx channels on, both rx channels off
    if (dut_en !== 4'b1010) begin
      report_error("tx only enables", 32'ha, wb_dat_t'(dut_en));
    end
    wb_write(REG_CTRL, '0);
    idle(3);
    end_test();

    check_on = 1'b0;
    $display("tests run %0d, passed %0d, failed %0d, errors %0d", tests_run,
             tests_run - tests_failed, tests_failed, total_errors);
    if (tests_failed == 0 && total_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- tb.f
logic/tdd_timing_pkg.sv
logic/tdd_regmap_pkg.sv
logic/tdd_cfg_if.sv
logic/tdd_regs.sv
logic/tdd_frame_timer.sv
logic/tdd_window_match.sv
logic/tdd_enable_gen.sv
logic/tdd_control.sv
tb/tdd_control_tb.sv

//--- Makefile
TOP  := tdd_control_tb
SRCS := $(shell cat tb.f)

.PHONY: run clean

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q '^>>> PASS$$' sim.log

obj_dir/V$(TOP): tb.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir sim.log
